// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/rv_alu.sv ====
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::alu_op_t op_i,
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    output rv_pkg::word_t   result_o,
    output logic            zero_o
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_OR:     result_o = a_i | b_i;
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SLT:    result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0); // Branch compare

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/10ps

module rv_core #(
    parameter rv_pkg::word_t BOOT_ADDR = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t instr_addr_o,
    input  rv_pkg::word_t instr_data_i,
    output logic          data_read_o,
    output logic          data_write_o,
    output rv_pkg::word_t data_addr_o,
    output rv_pkg::word_t data_wdata_o,
    input  rv_pkg::word_t data_rdata_i,
    input  logic          data_ready_i
);
    import rv_pkg::*;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        ctrl_t ctrl;
        word_t imm;
        word_t rs1_val;
        word_t rs2_val;
    } id_ex_t;

    typedef struct packed {
        word_t instr;
        ctrl_t ctrl;
        word_t alu_res;
        word_t store_data;
    } ex_mem_t;

    typedef struct packed {
        word_t instr;
        ctrl_t ctrl;
        word_t alu_res;
        word_t load_data;
    } mem_wb_t;

    word_t    pc;
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    ctrl_t    id_ctrl;
    word_t    id_imm;
    word_t    id_rs1_val;
    word_t    id_rs2_val;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     load_use_stall;
    logic     mem_stall;
    logic     hold_front;
    word_t    fwd_rs1;
    word_t    fwd_rs2;
    word_t    alu_b;
    word_t    alu_res;
    logic     alu_zero;
    logic     take_branch;
    logic     flush;
    word_t    branch_target;
    word_t    wb_value;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t exmem_val,
                                      word_t memwb_val);
        case (sel)
            FWD_EXMEM: return exmem_val;
            FWD_MEMWB: return memwb_val;
            default:   return reg_val;
        endcase
    endfunction

    always_ff @(posedge clk) begin // PC and IF/ID
        if (!rst_n) begin
            pc          <= BOOT_ADDR;
            if_id.instr <= NOP_INSTR;
        end else if (flush) begin
            pc          <= branch_target;
            if_id.instr <= NOP_INSTR;
        end else if (!hold_front) begin
            pc    <= pc + 32'd4;
            if_id <= '{pc: pc, instr: instr_data_i};
        end
    end

    always_ff @(posedge clk) begin // ID/EX
        if (!rst_n || flush || (load_use_stall && !mem_stall)) begin
            id_ex.instr <= NOP_INSTR;
            id_ex.ctrl  <= '0;
        end else if (mem_stall) begin
            // MEM/WB drains during the stall, so capture what was forwarded
            id_ex.rs1_val <= fwd_rs1;
            id_ex.rs2_val <= fwd_rs2;
        end else begin
            id_ex <= '{pc: if_id.pc, instr: if_id.instr, ctrl: id_ctrl, imm: id_imm,
                       rs1_val: id_rs1_val, rs2_val: id_rs2_val};
        end
    end

    always_ff @(posedge clk) begin // EX/MEM
        if (!rst_n) begin
            ex_mem.instr <= NOP_INSTR;
            ex_mem.ctrl  <= '0;
        end else if (!mem_stall) begin
            ex_mem <= '{instr: id_ex.instr, ctrl: id_ex.ctrl, alu_res: alu_res,
                        store_data: fwd_rs2};
        end
    end

    always_ff @(posedge clk) begin // MEM/WB
        if (!rst_n || mem_stall) begin
            mem_wb.instr <= NOP_INSTR;
            mem_wb.ctrl  <= '0;
        end else begin
            mem_wb <= '{instr: ex_mem.instr, ctrl: ex_mem.ctrl, alu_res: ex_mem.alu_res,
                        load_data: data_rdata_i};
        end
    end

    assign mem_stall  = (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write) && !data_ready_i;
    assign hold_front = mem_stall || load_use_stall;

    assign fwd_rs1 = fwd_mux(fwd_a, id_ex.rs1_val, ex_mem.alu_res, wb_value);
    assign fwd_rs2 = fwd_mux(fwd_b, id_ex.rs2_val, ex_mem.alu_res, wb_value);
    assign alu_b   = id_ex.ctrl.use_imm ? id_ex.imm : fwd_rs2;

    // Branch compares with SUB, BNE inverts the zero test
    assign branch_target = id_ex.pc + id_ex.imm;
    assign take_branch   = id_ex.ctrl.is_branch && (alu_zero != id_ex.ctrl.branch_ne);
    assign flush         = take_branch && !mem_stall;

    assign wb_value = mem_wb.ctrl.mem_read ? mem_wb.load_data : mem_wb.alu_res;

    assign instr_addr_o = pc;
    assign data_read_o  = ex_mem.ctrl.mem_read;
    assign data_write_o = ex_mem.ctrl.mem_write;
    assign data_addr_o  = ex_mem.alu_res;
    assign data_wdata_o = ex_mem.store_data;

    rv_decoder u_decoder (
        .instr_i (if_id.instr),
        .ctrl_o  (id_ctrl),
        .imm_o   (id_imm)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en_i    (mem_wb.ctrl.reg_write),
        .rd_addr_i  (mem_wb.instr[11:7]),
        .rd_data_i  (wb_value),
        .rs1_addr_i (if_id.instr[19:15]),
        .rs2_addr_i (if_id.instr[24:20]),
        .rs1_data_o (id_rs1_val),
        .rs2_data_o (id_rs2_val)
    );

    rv_alu u_alu (
        .op_i     (id_ex.ctrl.alu_op),
        .a_i      (fwd_rs1),
        .b_i      (alu_b),
        .result_o (alu_res),
        .zero_o   (alu_zero)
    );

    rv_hazard_unit u_hazard (
        .id_rs1_i         (if_id.instr[19:15]),
        .id_rs2_i         (if_id.instr[24:20]),
        .ex_rs1_i         (id_ex.instr[19:15]),
        .ex_rs2_i         (id_ex.instr[24:20]),
        .ex_rd_i          (id_ex.instr[11:7]),
        .mem_rd_i         (ex_mem.instr[11:7]),
        .wb_rd_i          (mem_wb.instr[11:7]),
        .ex_mem_read_i    (id_ex.ctrl.mem_read),
        .mem_reg_write_i  (ex_mem.ctrl.reg_write),
        .wb_reg_write_i   (mem_wb.ctrl.reg_write),
        .fwd_a_o          (fwd_a),
        .fwd_b_o          (fwd_b),
        .load_use_stall_o (load_use_stall)
    );

endmodule

// ==== source/rv_decoder.sv ====
`timescale 1ns/10ps

module rv_decoder (
    input  rv_pkg::word_t instr_i,
    output rv_pkg::ctrl_t ctrl_o,
    output rv_pkg::word_t imm_o
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;

    // Shared by R-type and I-type, SUB only exists in R-type
    function automatic alu_op_t arith_op(logic [2:0] f3, logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];

    always_comb begin
        ctrl_o = '0;
        imm_o  = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = arith_op(funct3, instr_i[30]);
            end
            OP_IMM: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.alu_op    = arith_op(funct3, 1'b0);
                imm_o            = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            OP_LUI: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.alu_op    = ALU_PASS_B;
                imm_o            = {instr_i[31:12], 12'h000};
            end
            OP_LOAD: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.mem_read  = 1'b1;
                ctrl_o.use_imm   = 1'b1;
                imm_o            = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            OP_STORE: begin
                ctrl_o.mem_write = 1'b1;
                ctrl_o.use_imm   = 1'b1;
                imm_o            = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OP_BRANCH: begin
                ctrl_o.is_branch = 1'b1;
                ctrl_o.branch_ne = funct3[0]; // BNE is funct3 001
                ctrl_o.alu_op    = ALU_SUB;
                imm_o            = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                    instr_i[11:8], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

// ==== source/rv_hazard_unit.sv ====
`timescale 1ns/10ps

module rv_hazard_unit (
    input  rv_pkg::reg_addr_t id_rs1_i,
    input  rv_pkg::reg_addr_t id_rs2_i,
    input  rv_pkg::reg_addr_t ex_rs1_i,
    input  rv_pkg::reg_addr_t ex_rs2_i,
    input  rv_pkg::reg_addr_t ex_rd_i,
    input  rv_pkg::reg_addr_t mem_rd_i,
    input  rv_pkg::reg_addr_t wb_rd_i,
    input  logic              ex_mem_read_i,
    input  logic              mem_reg_write_i,
    input  logic              wb_reg_write_i,
    output rv_pkg::fwd_sel_t  fwd_a_o,
    output rv_pkg::fwd_sel_t  fwd_b_o,
    output logic              load_use_stall_o
);
    import rv_pkg::*;

    // Youngest producer first
    function automatic fwd_sel_t fwd_select(reg_addr_t rs);
        if (rs == '0) begin
            return FWD_NONE;
        end
        if (mem_reg_write_i && (mem_rd_i == rs)) begin
            return FWD_EXMEM;
        end
        if (wb_reg_write_i && (wb_rd_i == rs)) begin
            return FWD_MEMWB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a_o = fwd_select(ex_rs1_i);
    assign fwd_b_o = fwd_select(ex_rs2_i);

    assign load_use_stall_o = ex_mem_read_i && (ex_rd_i != '0)
                              && ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    // RV32I major opcodes kept by this core
    localparam opcode_t OP_RTYPE  = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    localparam word_t NOP_INSTR = 32'h0000_0033; // add x0, x0, x0

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_SLL    = 4'd6;
    localparam alu_op_t ALU_SRL    = 4'd7;
    localparam alu_op_t ALU_PASS_B = 4'd8; // LUI

    localparam fwd_sel_t FWD_NONE  = 2'd0;
    localparam fwd_sel_t FWD_EXMEM = 2'd1;
    localparam fwd_sel_t FWD_MEMWB = 2'd2;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;   // ALU operand B from immediate
        logic    is_branch;
        logic    branch_ne; // BNE when set, BEQ otherwise
        alu_op_t alu_op;
    } ctrl_t;

endpackage

// ==== source/rv_regfile.sv ====
`timescale 1ns/10ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en_i,
    input  rv_pkg::reg_addr_t rd_addr_i,
    input  rv_pkg::word_t     rd_data_i,
    input  rv_pkg::reg_addr_t rs1_addr_i,
    input  rv_pkg::reg_addr_t rs2_addr_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o
);
    import rv_pkg::*;

    word_t regs [32];

    // Same-cycle write wins over the stored value
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en_i && (rd_addr_i == addr)) begin
            return rd_data_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n && wr_en_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

endmodule

// ==== src.f ====
source/rv_pkg.sv
source/rv_alu.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_hazard_unit.sv
source/rv_core.sv
test/tb_clock_gen.sv
test/rv_core_asserts.sv
test/rv_core_tb.sv

// ==== test/rv_core_asserts.sv ====
`timescale 1ns/10ps

module rv_core_asserts (
    input logic          clk,
    input logic          rst_n,
    input logic          data_read_o,
    input logic          data_write_o,
    input rv_pkg::word_t data_addr_o,
    input rv_pkg::word_t data_wdata_o,
    input logic          data_ready_i
);

    logic reset_seen = 1'b0; // Reset was already low at the previous edge

    always @(posedge clk) begin
        reset_seen <= !rst_n;
    end

    a_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read_o && data_write_o))
        else $error("Read and write requests are high together");

    a_read_held: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read_o && !data_ready_i) |=> (data_read_o && $stable(data_addr_o)))
        else $error("Pending read dropped or changed its address");

    a_write_held: assert property (@(posedge clk) disable iff (!rst_n)
        (data_write_o && !data_ready_i)
        |=> (data_write_o && $stable(data_addr_o) && $stable(data_wdata_o)))
        else $error("Pending write dropped or changed its address or data");

    a_quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && reset_seen) |-> (!data_read_o && !data_write_o))
        else $error("Data request made during reset");

endmodule

bind rv_core rv_core_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_read_o  (data_read_o),
    .data_write_o (data_write_o),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o),
    .data_ready_i (data_ready_i)
);

// ==== test/rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb;
    import rv_pkg::*;

    localparam word_t BOOT_ADDR = 32'h0000_0100;
    localparam int    PROG_MAX  = 128;
    localparam logic [2:0] R_F3 [8] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7};
    localparam logic [2:0] I_F3 [7] = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5};

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic   clk;
    logic   rst_n;
    word_t  instr_addr;
    word_t  instr_data;
    word_t  data_addr;
    word_t  data_wdata;
    word_t  data_rdata;
    logic   data_read;
    logic   data_write;
    logic   data_ready;
    word_t  prog [PROG_MAX];
    word_t  dmem [1024];
    store_t expected [$];
    int     prog_len;
    int     slot;
    int     errors;
    int     stores_seen;
    int     n_expected;
    int     cycles;
    int     delay;
    logic   busy;
    integer seed = 5;

    tb_clock_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    rv_core #(.BOOT_ADDR(BOOT_ADDR)) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_addr_o (instr_addr),
        .instr_data_i (instr_data),
        .data_read_o  (data_read),
        .data_write_o (data_write),
        .data_addr_o  (data_addr),
        .data_wdata_o (data_wdata),
        .data_rdata_i (data_rdata),
        .data_ready_i (data_ready)
    );

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'hA5A5_0F0F;
    endfunction

    function automatic word_t fetch_word(word_t pc);
        word_t idx;
        idx = (pc - BOOT_ADDR) >> 2;
        if (idx < PROG_MAX) begin
            return prog[idx[6:0]];
        end
        return NOP_INSTR;
    endfunction

    function automatic word_t r_type(logic sub, logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                     reg_addr_t rs2);
        return {1'b0, sub, 5'd0, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(logic [12:0] off, logic ne, reg_addr_t rs1, reg_addr_t rs2);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], OP_BRANCH};
    endfunction

    // ISA semantics of the kept arithmetic ops
    function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return a >> b[4:0];
            3'd6:    return a | b;
            3'd7:    return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // Instruction-level interpreter, fills the expected store list
    function automatic void run_reference();
        word_t     regs [32];
        word_t     mem [1024];
        word_t     pc;
        word_t     instr;
        word_t     a;
        word_t     b;
        word_t     res;
        word_t     addr;
        word_t     imm_b;
        reg_addr_t rd;
        logic      wr;
        logic      taken;
        foreach (regs[i]) regs[i] = 32'd0;
        foreach (mem[i]) mem[i] = fill_word(word_t'(i) << 2);
        pc = BOOT_ADDR;
        repeat (4 * PROG_MAX) begin
            instr = fetch_word(pc);
            a     = regs[instr[19:15]];
            b     = regs[instr[24:20]];
            rd    = instr[11:7];
            imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            res   = 32'd0;
            wr    = 1'b0;
            taken = 1'b0;
            case (instr[6:0])
                OP_RTYPE: begin
                    res = alu_ref(instr[14:12], instr[30], a, b);
                    wr  = 1'b1;
                end
                OP_IMM: begin
                    res = alu_ref(instr[14:12], 1'b0, a, {{20{instr[31]}}, instr[31:20]});
                    wr  = 1'b1;
                end
                OP_LUI: begin
                    res = {instr[31:12], 12'h000};
                    wr  = 1'b1;
                end
                OP_LOAD: begin
                    addr = a + {{20{instr[31]}}, instr[31:20]};
                    res  = mem[addr[11:2]];
                    wr   = 1'b1;
                end
                OP_STORE: begin
                    addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    mem[addr[11:2]] = b;
                    expected.push_back('{addr: addr, data: b});
                end
                OP_BRANCH: taken = (a == b) != instr[12];
                default: ;
            endcase
            if (wr && rd != 5'd0) regs[rd] = res;
            if (taken) begin
                if (imm_b == 32'd0) return; // Final spin loop
                pc = pc + imm_b;
            end else begin
                pc = pc + 32'd4;
            end
        end
    endfunction

    task automatic emit(word_t w);
        prog[prog_len[6:0]] = w;
        prog_len++;
    endtask

    task automatic store_next(reg_addr_t rs);
        emit(s_type(12'(slot * 4), rs, 5'd10));
        slot++;
    endtask

    task automatic check_value(string what, word_t got, word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    assign instr_data = fetch_word(instr_addr);

    // Data memory, answers after 0 to 3 cycles
    always @(negedge clk) begin
        data_ready = 1'b0;
        if (!rst_n) begin
            busy = 1'b0;
        end else if (data_read || data_write) begin
            if (!busy) begin
                busy  = 1'b1;
                delay = $random(seed) & 3;
            end
            if (delay == 0) begin
                busy       = 1'b0;
                data_ready = 1'b1;
                if (data_read) data_rdata = dmem[data_addr[11:2]];
                else dmem[data_addr[11:2]] = data_wdata;
            end else begin
                delay--;
            end
        end
    end

    always @(posedge clk) begin
        store_t exp_st;
        if (rst_n && data_write && data_ready) begin
            if (expected.size() == 0) begin
                errors++;
                $display("Unexpected store to %h after the last expected one", data_addr);
            end else begin
                exp_st = expected.pop_front();
                check_value("store address", data_addr, exp_st.addr);
                check_value("store data", data_wdata, exp_st.data);
                stores_seen++;
            end
        end
    end

    initial begin
        logic [11:0] imm;
        data_ready  = 1'b0;
        data_rdata  = 32'd0;
        busy        = 1'b0;
        delay       = 0;
        prog_len    = 0;
        slot        = 0;
        errors      = 0;
        stores_seen = 0;
        cycles      = 0;
        foreach (prog[i]) prog[i] = NOP_INSTR;
        foreach (dmem[i]) dmem[i] = fill_word(word_t'(i) << 2);

        for (int r = 1; r <= 12; r++) begin
            emit(i_type(12'($random(seed)), 5'd0, 3'd0, reg_addr_t'(r), OP_IMM));
        end
        emit(i_type(12'd512, 5'd0, 3'd0, 5'd10, OP_IMM)); // Store base
        emit({20'($random(seed)), 5'd9, OP_LUI});
        store_next(5'd9);
        for (int k = 0; k < 8; k++) begin // R-type chain through x11
            emit(r_type(k == 1, R_F3[k], 5'd11, 5'd11, reg_addr_t'(k + 1)));
            store_next(5'd11);
        end
        for (int k = 0; k < 7; k++) begin
            imm = 12'($random(seed));
            if (I_F3[k] == 3'd1 || I_F3[k] == 3'd5) imm = imm & 12'h01f;
            emit(i_type(imm, 5'd12, I_F3[k], 5'd12, OP_IMM));
            store_next(5'd12);
        end
        // Distance two and three dependencies
        emit(r_type(1'b0, 3'd0, 5'd14, 5'd1, 5'd2));
        emit(i_type(12'd7, 5'd3, 3'd0, 5'd15, OP_IMM));
        emit(r_type(1'b0, 3'd0, 5'd16, 5'd14, 5'd3));
        emit(r_type(1'b0, 3'd0, 5'd17, 5'd14, 5'd15));
        store_next(5'd16);
        store_next(5'd17);
        // Load-use on ALU operand and on store data
        emit(i_type(12'd0, 5'd10, 3'b010, 5'd18, OP_LOAD));
        emit(r_type(1'b0, 3'd0, 5'd19, 5'd18, 5'd1));
        store_next(5'd19);
        emit(i_type(12'h100, 5'd10, 3'b010, 5'd20, OP_LOAD));
        store_next(5'd20);
        // Taken, not taken, forwarded compare, data dependent
        emit(b_type(13'd12, 1'b0, 5'd1, 5'd1));
        store_next(5'd1);
        store_next(5'd2);
        store_next(5'd3);
        emit(b_type(13'd12, 1'b1, 5'd1, 5'd1));
        store_next(5'd4);
        store_next(5'd5);
        store_next(5'd6);
        emit(r_type(1'b1, 3'd0, 5'd21, 5'd1, 5'd2));
        emit(b_type(13'd12, 1'b0, 5'd21, 5'd0));
        store_next(5'd7);
        store_next(5'd8);
        store_next(5'd21);
        emit(b_type(13'd12, 1'b1, 5'd1, 5'd2));
        store_next(5'd3);
        store_next(5'd4);
        store_next(5'd5);
        emit(b_type(13'd0, 1'b0, 5'd0, 5'd0));

        run_reference();
        n_expected = expected.size();

        @(posedge rst_n);
        #1;
        check_value("first fetch address", instr_addr, BOOT_ADDR);
        check_value("read request after reset", 32'(data_read), 32'd0);
        check_value("write request after reset", 32'(data_write), 32'd0);

        while (stores_seen < n_expected && cycles < prog_len * 12 + 100) begin
            @(posedge clk);
            cycles++;
        end
        if (stores_seen < n_expected) begin
            errors++;
            $display("Timeout after %0d cycles: only %0d of %0d expected stores were seen",
                     cycles, stores_seen, n_expected);
        end
        $display("Summary: %0d errors, %0d of %0d stores checked", errors, stores_seen,
                 n_expected);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk); // Release away from the sampling edge
        rst_n = 1'b1;
    end

endmodule
